/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = memoryHandlerTb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/accessSequencer.sv */
`include "memoryHandler_cfg.svh"

module accessSequencer (
    input  logic            clk,
    input  logic            nrst,
    input  logic            busy_i,
    input  memPkg::memReq_t memReq_i,
    input  memPkg::word_t   instr_i,
    input  memPkg::word_t   loadWord_i,
    input  memPkg::word_t   storeWord_i,
    output memPkg::busReq_t busReq_o,
    output memPkg::word_t   regData_o,
    output memPkg::word_t   instruction_o,
    output logic            freeze_o
);
    import memPkg::*;

    mhState_t state;
    mhState_t stateNext;
    logic     busyPrev;
    logic     busyFall;
    addr_t    addrReg;

    // busy edge detector
    always_ff @(posedge clk) begin
        if (!nrst) begin
            busyPrev <= 1'b0;
        end else begin
            busyPrev <= busy_i;
        end
    end

    assign busyFall = busyPrev && !busy_i; // access done this cycle

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= FETCH;
        end else begin
            state <= stateNext;
        end
    end

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            FETCH: begin
                if (busyFall) begin
                    stateNext = F_WAIT;
                end
            end
            F_WAIT: begin
                stateNext = DATA;
            end
            DATA: begin
                // store wins if both flags are set
                if (memReq_i.memWrite) begin
                    stateNext = STORE;
                end else if (memReq_i.memRead) begin
                    stateNext = LOAD;
                end else begin
                    stateNext = INC;
                end
            end
            LOAD, STORE: begin
                if (busyFall) begin
                    stateNext = INC;
                end
            end
            INC: begin
                stateNext = INC_WAIT;
            end
            INC_WAIT: begin
                stateNext = FETCH;
            end
            default: begin
                stateNext = FETCH;
            end
        endcase
    end

    // address is latched in DATA so it is stable for the whole access
    always_ff @(posedge clk) begin
        if (!nrst) begin
            addrReg <= '0;
        end else if (state == DATA && (memReq_i.memRead || memReq_i.memWrite)) begin
            addrReg <= memReq_i.address;
        end
    end

    // load result lands on the edge and is valid from INC
    always_ff @(posedge clk) begin
        if (!nrst) begin
            regData_o <= '0;
        end else if (state == LOAD && busyFall) begin
            regData_o <= loadWord_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            instruction_o <= '0;
        end else if (state == F_WAIT && instr_i != `MH_IDLE_WORD) begin
            instruction_o <= instr_i; // idle pattern keeps the old word
        end
    end

    // bus request follows the state
    always_comb begin
        busReq_o.addr = addrReg;
        busReq_o.data = `MH_IDLE_WORD;
        case (state)
            FETCH: begin
                busReq_o.op = BUS_FETCH;
            end
            LOAD: begin
                busReq_o.op = BUS_READ;
            end
            STORE: begin
                busReq_o.op   = BUS_WRITE;
                busReq_o.data = storeWord_i; // only place real data goes out
            end
            default: begin
                busReq_o.op = BUS_IDLE;
            end
        endcase
    end

    assign freeze_o = (state != INC); // cpu steps once per instruction

endmodule

/* src/loadAligner.sv */
`include "memoryHandler_cfg.svh"

module loadAligner (
    input  memPkg::memOp_t memOp_i,
    input  memPkg::word_t  rawWord_i,
    output memPkg::word_t  loadWord_o
);
    import memPkg::*;

    logic [`MH_BYTE_W-1:0] lowByte;
    logic [`MH_HALF_W-1:0] lowHalf;
    logic                  byteSign;
    logic                  halfSign;

    assign lowByte  = rawWord_i[`MH_BYTE_W-1:0];
    assign lowHalf  = rawWord_i[`MH_HALF_W-1:0];
    assign byteSign = lowByte[`MH_BYTE_W-1];
    assign halfSign = lowHalf[`MH_HALF_W-1];

    always_comb begin
        case (memOp_i)
            LB: begin
                // sign extend byte
                loadWord_o = {{(`MH_DATA_W-`MH_BYTE_W){byteSign}}, lowByte};
            end
            LH: begin
                loadWord_o = {{(`MH_DATA_W-`MH_HALF_W){halfSign}}, lowHalf};
            end
            LW: begin
                loadWord_o = rawWord_i; // full word as is
            end
            LBU: begin
                loadWord_o = {{(`MH_DATA_W-`MH_BYTE_W){1'b0}}, lowByte};
            end
            LHU: begin
                loadWord_o = {{(`MH_DATA_W-`MH_HALF_W){1'b0}}, lowHalf};
            end
            default: begin
                // stores and none never write the register
                loadWord_o = '0;
            end
        endcase
    end

endmodule

/* src/memPkg.sv */
`include "memoryHandler_cfg.svh"

package memPkg;

    typedef logic [`MH_DATA_W-1:0] word_t;
    typedef logic [`MH_ADDR_W-1:0] addr_t;

    // load/store op from the decoder
    typedef enum logic [3:0] {
        NONE = `MH_OP_NONE,
        LB   = `MH_OP_LB,
        LH   = `MH_OP_LH,
        LW   = `MH_OP_LW,
        LBU  = `MH_OP_LBU,
        LHU  = `MH_OP_LHU,
        SB   = `MH_OP_SB,
        SH   = `MH_OP_SH,
        SW   = `MH_OP_SW
    } memOp_t;

    // request kind seen by the bus
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_WRITE = 2'b01,
        BUS_READ  = 2'b10,
        BUS_FETCH = 2'b11
    } busOp_t;

    typedef enum logic [2:0] {
        INC      = 3'd0, // only cycle where the cpu runs
        FETCH    = 3'd1,
        F_WAIT   = 3'd2,
        DATA     = 3'd3,
        LOAD     = 3'd4,
        STORE    = 3'd5,
        INC_WAIT = 3'd6
    } mhState_t;

    // what the current instruction wants from memory
    typedef struct packed {
        memOp_t memOp;
        logic   memWrite;
        logic   memRead;
        logic   memSource; // 1 = fpu register
        addr_t  address;
    } memReq_t;

    typedef struct packed {
        busOp_t op;
        addr_t  addr;
        word_t  data;
    } busReq_t;

endpackage

/* src/memoryHandler.sv */
module memoryHandler (
    input  logic            clk,
    input  logic            nrst,
    input  logic            busy_i,
    input  memPkg::memReq_t memReq_i,
    input  memPkg::word_t   regData_i,
    input  memPkg::word_t   fpuData_i,
    input  memPkg::word_t   dataMmio_i,
    input  memPkg::word_t   instr_i,
    output memPkg::busReq_t busReq_o,
    output memPkg::word_t   regData_o,
    output memPkg::word_t   instruction_o,
    output logic            freeze_o
);
    import memPkg::*;

    word_t loadWord;
    word_t storeWord;

    // bus read data to register value
    loadAligner i_loadAligner (
        .memOp_i    (memReq_i.memOp),
        .rawWord_i  (dataMmio_i),
        .loadWord_o (loadWord)
    );

    // register value to bus write data
    storeAligner i_storeAligner (
        .memOp_i     (memReq_i.memOp),
        .fromFpu_i   (memReq_i.memSource),
        .regWord_i   (regData_i),
        .fpuWord_i   (fpuData_i),
        .storeWord_o (storeWord)
    );

    accessSequencer i_accessSequencer (
        .clk           (clk),
        .nrst          (nrst),
        .busy_i        (busy_i),
        .memReq_i      (memReq_i),
        .instr_i       (instr_i),
        .loadWord_i    (loadWord),
        .storeWord_i   (storeWord),
        .busReq_o      (busReq_o),
        .regData_o     (regData_o),
        .instruction_o (instruction_o),
        .freeze_o      (freeze_o)
    );

endmodule

/* src/memoryHandler_cfg.svh */
`ifndef MEMORY_HANDLER_CFG_SVH
`define MEMORY_HANDLER_CFG_SVH

// bus and register widths
`define MH_DATA_W 32
`define MH_ADDR_W 32

// sub-word sizes used by the aligners
`define MH_BYTE_W 8
`define MH_HALF_W 16

// bus data pattern meaning nothing valid
`define MH_IDLE_WORD 32'hDEAD_BEEF

// memory op codes as the decoder issues them
`define MH_OP_NONE 4'd0
`define MH_OP_LB   4'd1
`define MH_OP_LH   4'd2
`define MH_OP_LW   4'd3
`define MH_OP_LBU  4'd4
`define MH_OP_LHU  4'd5
`define MH_OP_SB   4'd6
`define MH_OP_SH   4'd7
`define MH_OP_SW   4'd8

`endif

/* src/storeAligner.sv */
`include "memoryHandler_cfg.svh"

module storeAligner (
    input  memPkg::memOp_t memOp_i,
    input  logic           fromFpu_i,
    input  memPkg::word_t  regWord_i,
    input  memPkg::word_t  fpuWord_i,
    output memPkg::word_t  storeWord_o
);
    import memPkg::*;

    word_t srcWord;

    // fpu or integer register file
    assign srcWord = fromFpu_i ? fpuWord_i : regWord_i;

    always_comb begin
        case (memOp_i)
            SB: begin
                storeWord_o = {{(`MH_DATA_W-`MH_BYTE_W){1'b0}},
                               srcWord[`MH_BYTE_W-1:0]};
            end
            SH: begin
                storeWord_o = {{(`MH_DATA_W-`MH_HALF_W){1'b0}},
                               srcWord[`MH_HALF_W-1:0]};
            end
            SW: begin
                storeWord_o = srcWord;
            end
            default: begin
                storeWord_o = '0; // not a store
            end
        endcase
    end

endmodule

/* verification/memoryHandlerChecker.sv */
`include "memoryHandler_cfg.svh"

module memoryHandlerChecker (
    input  logic            clk,
    input  logic            nrst,
    input  memPkg::memReq_t memReq_i,
    input  memPkg::word_t   expRegData_i,
    input  memPkg::word_t   expStore_i,
    input  memPkg::word_t   expInstr_i,
    input  memPkg::busReq_t busReq_i,
    input  memPkg::word_t   regData_i,
    input  memPkg::word_t   instruction_i,
    input  logic            freeze_i,
    output int              errorCount_o,
    output int              checkCount_o
);
    import memPkg::*;

    int      errors = 0;
    int      checks = 0;
    memReq_t heldReq;     // request of the instruction being stepped
    word_t   heldRegData;
    word_t   heldInstr;
    logic    resetChecked;
    logic    sawAccess;   // READ or WRITE seen since the last fetch
    int      lowCycles;
    busOp_t  prevOp;
    logic    prevFreeze;

    assign errorCount_o = errors;
    assign checkCount_o = checks;

    task automatic compareWord(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkTrue(input logic ok, input string what);
        checks++;
        if (ok !== 1'b1) begin
            errors++;
            $display("MISMATCH at %0t: %s", $time, what);
        end
    endtask

    task automatic checkBus;
        case (busReq_i.op)
            BUS_WRITE: begin
                sawAccess = 1'b1;
                checkTrue(memReq_i.memWrite, "WRITE request for an instruction without a store");
                compareWord("store data", busReq_i.data, expStore_i);
                compareWord("store address", busReq_i.addr, memReq_i.address);
            end
            BUS_READ: begin
                sawAccess = 1'b1;
                checkTrue(memReq_i.memRead && !memReq_i.memWrite,
                          "READ request for an instruction without a load");
                compareWord("load address", busReq_i.addr, memReq_i.address);
                compareWord("bus data during load", busReq_i.data, `MH_IDLE_WORD);
            end
            default: begin
                compareWord("bus data outside a store", busReq_i.data, `MH_IDLE_WORD);
            end
        endcase
    endtask

    task automatic checkStep;
        if (freeze_i) begin
            heldReq     = memReq_i;
            heldRegData = expRegData_i;
            heldInstr   = expInstr_i;
        end else begin
            lowCycles++;
            checkTrue(prevFreeze, "freeze_o low for two cycles in a row");
            compareWord("regData_o at step", regData_i, heldRegData);
            compareWord("instruction_o at step", instruction_i, heldInstr);
            checkTrue(sawAccess == (heldReq.memRead || heldReq.memWrite),
                      "bus access does not match the memory flags");
        end
        // a new instruction starts with a fresh FETCH request
        if (busReq_i.op == BUS_FETCH && prevOp != BUS_FETCH) begin
            checkTrue(lowCycles == 1, "freeze_o not low exactly once in the last instruction");
            lowCycles = 0;
            sawAccess = 1'b0;
        end
    endtask

    // outputs sampled on the rising edge before they update
    always @(posedge clk) begin
        if (!nrst) begin
            resetChecked = 1'b0;
            sawAccess    = 1'b0;
            lowCycles    = 0;
            prevOp       = BUS_FETCH;
            prevFreeze   = 1'b1;
        end else begin
            if (!resetChecked) begin
                checkTrue(busReq_i.op == BUS_FETCH, "bus op after reset is not FETCH");
                checkTrue(freeze_i, "freeze_o low right after reset");
                compareWord("regData_o after reset", regData_i, '0);
                compareWord("instruction_o after reset", instruction_i, '0);
                resetChecked = 1'b1;
            end
            checkBus();
            checkStep();
            prevOp     = busReq_i.op;
            prevFreeze = freeze_i;
        end
    end

endmodule

/* verification/memoryHandlerTb.sv */
`include "memoryHandler_cfg.svh"

module memoryHandlerTb;
    import memPkg::*;

    localparam int NUM_LINES  = 18;
    localparam int FIELDS     = 12;  // words per line of the data file
    localparam int REQ_LIMIT  = 64;  // cycles to wait for a bus request
    localparam int STEP_LIMIT = 16;

    logic    clk;
    logic    nrst;
    logic    busy;
    memReq_t memReq;
    word_t   regData;
    word_t   fpuData;
    word_t   dataMmio;
    word_t   instr;
    busReq_t busReq;
    word_t   regDataOut;
    word_t   instructionOut;
    logic    freeze;
    word_t   expRegData;
    word_t   expStore;
    word_t   expInstr;
    word_t   curFetch;  // bus answers of the current line
    word_t   curRead;
    word_t   testData [0:255];
    integer  seed;
    int      timeouts;
    int      errorCount;
    int      checkCount;

    tbClock i_clock (
        .clk_o  (clk),
        .nrst_o (nrst)
    );

    memoryHandler i_dut (
        .clk           (clk),
        .nrst          (nrst),
        .busy_i        (busy),
        .memReq_i      (memReq),
        .regData_i     (regData),
        .fpuData_i     (fpuData),
        .dataMmio_i    (dataMmio),
        .instr_i       (instr),
        .busReq_o      (busReq),
        .regData_o     (regDataOut),
        .instruction_o (instructionOut),
        .freeze_o      (freeze)
    );

    memoryHandlerChecker i_checker (
        .clk           (clk),
        .nrst          (nrst),
        .memReq_i      (memReq),
        .expRegData_i  (expRegData),
        .expStore_i    (expStore),
        .expInstr_i    (expInstr),
        .busReq_i      (busReq),
        .regData_i     (regDataOut),
        .instruction_i (instructionOut),
        .freeze_i      (freeze),
        .errorCount_o  (errorCount),
        .checkCount_o  (checkCount)
    );

    function automatic word_t field(input int line, input int k);
        logic [7:0] idx;
        idx = 8'(line * FIELDS + k);
        return testData[idx];
    endfunction

    task automatic applyLine(input int line);
        memReq.memOp     = memOp_t'(4'(field(line, 1)));
        memReq.memWrite  = field(line, 2) != 0;
        memReq.memRead   = field(line, 3) != 0;
        memReq.memSource = field(line, 4) != 0;
        memReq.address   = field(line, 5);
        regData    = field(line, 6);
        fpuData    = field(line, 7);
        curFetch   = field(line, 0);
        curRead    = field(line, 8);
        expRegData = field(line, 9);
        expStore   = field(line, 10);
        expInstr   = field(line, 11);
    endtask

    // reset is released on a falling edge, so look on the rising one
    task automatic waitReset;
        int n;
        n = 0;
        while (nrst !== 1'b1 && n < STEP_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (nrst !== 1'b1) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
    endtask

    // bus model answering one request after a random busy time
    task automatic serveBus;
        int     n;
        int     r;
        int     busyLen;
        busOp_t kind;
        n = 0;
        @(negedge clk);
        while (busReq.op == BUS_IDLE && n < REQ_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busReq.op == BUS_IDLE) begin
            $display("timeout: no bus request within %0d cycles", REQ_LIMIT);
            timeouts++;
        end else begin
            r       = $random(seed);
            busyLen = 1 + (r & 3);
            kind    = busReq.op;
            busy    = 1'b1;
            if (kind == BUS_FETCH) begin
                instr = `MH_IDLE_WORD;
            end else if (kind == BUS_READ) begin
                dataMmio = `MH_IDLE_WORD;
            end
            repeat (busyLen) @(negedge clk);
            busy = 1'b0; // data valid together with the falling busy
            if (kind == BUS_FETCH) begin
                instr = curFetch;
            end else if (kind == BUS_READ) begin
                dataMmio = curRead;
            end
        end
    endtask

    task automatic waitFreezeLow;
        int n;
        n = 0;
        while (freeze && n < STEP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (freeze) begin
            $display("timeout: freeze_o stayed high for %0d cycles", STEP_LIMIT);
            timeouts++;
        end
    endtask

    task automatic waitFetch;
        int n;
        n = 0;
        while (busReq.op != BUS_FETCH && n < STEP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busReq.op != BUS_FETCH) begin
            $display("timeout: no FETCH request after the last instruction");
            timeouts++;
        end
    endtask

    initial begin
        seed       = 57433;
        timeouts   = 0;
        busy       = 1'b0;
        memReq     = '0;
        regData    = '0;
        fpuData    = '0;
        dataMmio   = `MH_IDLE_WORD;
        instr      = `MH_IDLE_WORD;
        expRegData = '0;
        expStore   = '0;
        expInstr   = '0;
        $readmemh("verification/memoryHandler_testdata.txt", testData);
        applyLine(0);
        waitReset();
        for (int i = 0; i < NUM_LINES && timeouts == 0; i++) begin
            serveBus(); // fetch
            if (timeouts == 0 && (memReq.memRead || memReq.memWrite)) begin
                serveBus();
            end
            if (timeouts == 0) begin
                waitFreezeLow();
            end
            // cpu steps here so the next instruction's inputs go in
            if (timeouts == 0 && i + 1 < NUM_LINES) begin
                applyLine(i + 1);
            end
        end
        // the next FETCH lets the checker close the last instruction
        if (timeouts == 0) begin
            waitFetch();
        end
        @(negedge clk);
        $display("checks %0d mismatches %0d timeouts %0d", checkCount, errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/memoryHandler_testdata.txt */
// instr memOp memWrite memRead memSource address regWord fpuWord busRead
// expRegData expStore expInstr (all hex, one instruction per line)
00000013 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00000000 00000013
00410083 1 0 1 0 00001000 00000000 00000000 123456F0 FFFFFFF0 00000000 00410083
00510103 1 0 1 0 00001004 00000000 00000000 8765437F 0000007F 00000000 00510103
00611183 2 0 1 0 00001008 00000000 00000000 00008001 FFFF8001 00000000 00611183
00711203 2 0 1 0 0000100A 00000000 00000000 FFFF7FFE 00007FFE 00000000 00711203
00812283 3 0 1 0 0000100C 00000000 00000000 CAFEF00D CAFEF00D 00000000 00812283
00914303 4 0 1 0 00001010 00000000 00000000 123456A5 000000A5 00000000 00914303
00A15383 5 0 1 0 00001014 00000000 00000000 0102B00B 0000B00B 00000000 00A15383
DEADBEEF 0 0 0 0 00000000 00000000 00000000 00000000 0000B00B 00000000 00A15383
00B10023 6 1 0 0 00002000 11223344 55667788 00000000 0000B00B 00000044 00B10023
00C11027 7 1 0 1 00002002 AABBCCDD 99887766 00000000 0000B00B 00007766 00C11027
00D12023 8 1 0 0 00002004 89ABCDEF 01234567 00000000 0000B00B 89ABCDEF 00D12023
00E12027 8 1 0 1 00002008 00000000 3F800000 00000000 0000B00B 3F800000 00E12027
00F10023 6 1 0 1 0000200C FFFFFFFF 000012AB 00000000 0000B00B 000000AB 00F10023
00208133 0 0 0 0 00000000 00000000 00000000 00000000 0000B00B 00000000 00208133
01012003 3 0 1 0 00003000 00000000 00000000 DEADBEEF DEADBEEF 00000000 01012003
01114083 5 0 1 0 00003006 00000000 00000000 80008000 00008000 00000000 01114083
01215023 7 1 0 0 00003008 1234ABCD 00000000 00000000 00008000 0000ABCD 01215023

/* verification/tbClock.sv */
module tbClock #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset held over two rising edges and released mid cycle
    initial begin
        nrst_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        nrst_o = 1'b1;
    end

endmodule

/* verilog.f */
+incdir+src
src/memPkg.sv
src/loadAligner.sv
src/storeAligner.sv
src/accessSequencer.sv
src/memoryHandler.sv
verification/tbClock.sv
verification/memoryHandlerChecker.sv
verification/memoryHandlerTb.sv
